// ==== rtl/decode_pkg.sv ====
package decode_pkg;

   localparam int XLEN      = 64;
   localparam int OP_W      = 7;   // 66 op codes
   localparam int REG_W     = 5;
   localparam int IMM_FMT_W = 3;
   localparam int BUF_DEPTH = 2;
   // op, three regs, three valid bits, imm, four flags
   localparam int UOP_W     = OP_W + 3 * REG_W + 3 + XLEN + 4;

   typedef logic [31:0]          insn_t;
   typedef logic [XLEN-1:0]      xlen_t;
   typedef logic [REG_W-1:0]     reg_idx_t;
   typedef logic [OP_W-1:0]      uop_op_t;
   typedef logic [IMM_FMT_W-1:0] imm_fmt_t;
   typedef logic [UOP_W-1:0]     uop_vec_t;

   localparam uop_op_t OP_II   = 7'd0,  OP_NOP  = 7'd1,  OP_ADDU = 7'd2,  OP_SUBU = 7'd3,
                       OP_SLL  = 7'd4,  OP_SLT  = 7'd5,  OP_SLTU = 7'd6,  OP_XOR  = 7'd7,
                       OP_SRL  = 7'd8,  OP_SRA  = 7'd9,  OP_OR   = 7'd10, OP_AND  = 7'd11;

   localparam uop_op_t OP_ADDI = 7'd12, OP_SLLI = 7'd13, OP_SLTI = 7'd14, OP_SLTIU = 7'd15,
                       OP_XORI = 7'd16, OP_SRLI = 7'd17, OP_SRAI = 7'd18, OP_ORI   = 7'd19,
                       OP_ANDI = 7'd20;

   localparam uop_op_t OP_LUI  = 7'd21, OP_AUIPC = 7'd22;

   localparam uop_op_t OP_ADDIW = 7'd23, OP_SLLIW = 7'd24, OP_SRLIW = 7'd25,
                       OP_SRAIW = 7'd26, OP_ADDW  = 7'd27, OP_SUBW  = 7'd28,
                       OP_SLLW  = 7'd29, OP_SRLW  = 7'd30, OP_SRAW  = 7'd31;

   localparam uop_op_t OP_MUL  = 7'd32, OP_MULH  = 7'd33, OP_MULHU = 7'd34,
                       OP_DIV  = 7'd35, OP_DIVU  = 7'd36, OP_REM   = 7'd37,
                       OP_REMU = 7'd38, OP_MULW  = 7'd39, OP_DIVW  = 7'd40,
                       OP_DIVUW = 7'd41, OP_REMW = 7'd42, OP_REMUW = 7'd43;

   localparam uop_op_t OP_LB  = 7'd44, OP_LH  = 7'd45, OP_LW  = 7'd46, OP_LD = 7'd47,
                       OP_LBU = 7'd48, OP_LHU = 7'd49, OP_LWU = 7'd50,
                       OP_SB  = 7'd51, OP_SH  = 7'd52, OP_SW  = 7'd53, OP_SD = 7'd54;

   localparam uop_op_t OP_BEQ  = 7'd55, OP_BNE  = 7'd56, OP_BLT = 7'd57, OP_BGE  = 7'd58,
                       OP_BLTU = 7'd59, OP_BGEU = 7'd60, OP_J   = 7'd61, OP_JAL  = 7'd62,
                       OP_JR   = 7'd63, OP_JALR = 7'd64, OP_RET = 7'd65;

   // immediate formats, the _PC ones are added to the pc
   localparam imm_fmt_t IMM_NONE = 3'd0;
   localparam imm_fmt_t IMM_I    = 3'd1;
   localparam imm_fmt_t IMM_S    = 3'd2;
   localparam imm_fmt_t IMM_U    = 3'd3;
   localparam imm_fmt_t IMM_B_PC = 3'd4;
   localparam imm_fmt_t IMM_J_PC = 3'd5;
   localparam imm_fmt_t IMM_U_PC = 3'd6;

   localparam logic [6:0] OPC_LOAD      = 7'h03;
   localparam logic [6:0] OPC_MISC_MEM  = 7'h0f;
   localparam logic [6:0] OPC_OP_IMM    = 7'h13;
   localparam logic [6:0] OPC_AUIPC     = 7'h17;
   localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
   localparam logic [6:0] OPC_STORE     = 7'h23;
   localparam logic [6:0] OPC_OP        = 7'h33;
   localparam logic [6:0] OPC_LUI       = 7'h37;
   localparam logic [6:0] OPC_OP_32     = 7'h3b;
   localparam logic [6:0] OPC_BRANCH    = 7'h63;
   localparam logic [6:0] OPC_JALR      = 7'h67;
   localparam logic [6:0] OPC_JAL       = 7'h6f;

endpackage

// ==== rtl/uop_if.sv ====
`timescale 1ns/1ps

interface uop_if import decode_pkg::*; ();

   uop_op_t  op;
   reg_idx_t dst;
   logic     dst_valid;
   reg_idx_t src_a;
   logic     src_a_valid;
   reg_idx_t src_b;
   logic     src_b_valid;
   logic     is_int;
   logic     is_mem;
   logic     is_store;
   logic     is_br;
   imm_fmt_t imm_fmt;   // decoder to imm_gen only
   xlen_t    imm;

   modport dec (output op, dst, dst_valid, src_a, src_a_valid, src_b, src_b_valid,
                       is_int, is_mem, is_store, is_br, imm_fmt);

   modport gen (input imm_fmt, output imm);

   modport sink (input op, dst, dst_valid, src_a, src_a_valid, src_b, src_b_valid,
                       is_int, is_mem, is_store, is_br, imm);

endinterface

// ==== rtl/op_decode.sv ====
`timescale 1ns/1ps

module op_decode import decode_pkg::*;
(
   input  insn_t insn,
   input  logic  mode64,
   uop_if.dec    u
);

   logic [6:0] opcode;
   logic [2:0] f3;
   logic [6:0] f7;
   reg_idx_t   rd;
   reg_idx_t   rs1;
   reg_idx_t   rs2;

   uop_op_t    op;
   reg_idx_t   dst;
   reg_idx_t   src_a;
   reg_idx_t   src_b;
   logic       dst_valid;
   logic       src_a_valid;
   logic       src_b_valid;
   logic       is_int;
   logic       is_mem;
   logic       is_store;
   logic       is_br;
   logic       alu_wr;   // result is dropped when rd is x0
   imm_fmt_t   imm_fmt;

   assign opcode = insn[6:0];
   assign f3     = insn[14:12];
   assign f7     = insn[31:25];
   assign rd     = insn[11:7];
   assign rs1    = insn[19:15];
   assign rs2    = insn[24:20];

   always_comb
   begin
      op          = OP_II;
      dst         = '0;
      src_a       = '0;
      src_b       = '0;
      src_a_valid = 1'b0;
      src_b_valid = 1'b0;
      is_int      = 1'b0;
      is_mem      = 1'b0;
      is_store    = 1'b0;
      is_br       = 1'b0;
      alu_wr      = 1'b0;
      imm_fmt     = IMM_NONE;
      case (opcode)
         OPC_LOAD:
         begin
            dst         = rd;
            src_a       = rs1;
            src_a_valid = 1'b1;
            is_mem      = 1'b1;
            imm_fmt     = IMM_I;
            case (f3)
               3'd0: op = OP_LB;
               3'd1: op = OP_LH;
               3'd2: op = OP_LW;
               3'd3: op = OP_LD;
               3'd4: op = OP_LBU;
               3'd5: op = OP_LHU;
               3'd6: op = OP_LWU;
               default: op = OP_II;
            endcase
         end
         OPC_MISC_MEM: op = OP_NOP;   // fence needs no work here
         OPC_OP_IMM:
         begin
            dst         = rd;
            src_a       = rs1;
            src_a_valid = 1'b1;
            is_int      = 1'b1;
            alu_wr      = 1'b1;
            imm_fmt     = IMM_I;
            case (f3)
               3'd0: op = OP_ADDI;
               3'd1: op = (insn[31:26] == 6'h00) ? OP_SLLI : OP_II;
               3'd2: op = OP_SLTI;
               3'd3: op = OP_SLTIU;
               3'd4: op = OP_XORI;
               3'd5: op = (insn[31:26] == 6'h00) ? OP_SRLI :
                          (insn[31:26] == 6'h10) ? OP_SRAI : OP_II;
               3'd6: op = OP_ORI;
               default: op = OP_ANDI;
            endcase
         end
         OPC_AUIPC:
         begin
            dst     = rd;
            is_int  = 1'b1;
            alu_wr  = 1'b1;
            imm_fmt = IMM_U_PC;
            op      = OP_AUIPC;
         end
         OPC_OP_IMM_32:
         begin
            if (mode64)
            begin
               dst         = rd;
               src_a       = rs1;
               src_a_valid = 1'b1;
               is_int      = 1'b1;
               alu_wr      = 1'b1;
               imm_fmt     = IMM_I;
               case ({f7, f3})
                  {7'h00, 3'd1}: op = OP_SLLIW;
                  {7'h00, 3'd5}: op = OP_SRLIW;
                  {7'h20, 3'd5}: op = OP_SRAIW;
                  default: op = (f3 == 3'd0) ? OP_ADDIW : OP_II;   // addiw ignores f7
               endcase
            end
         end
         OPC_STORE:
         begin
            src_a       = rs1;
            src_b       = rs2;
            src_a_valid = 1'b1;
            src_b_valid = 1'b1;
            is_mem      = 1'b1;
            is_store    = 1'b1;
            imm_fmt     = IMM_S;
            case (f3)
               3'd0: op = OP_SB;
               3'd1: op = OP_SH;
               3'd2: op = OP_SW;
               3'd3: op = OP_SD;
               default: op = OP_II;
            endcase
         end
         OPC_OP, OPC_OP_32:
         begin
            dst         = rd;
            src_a       = rs1;
            src_b       = rs2;
            src_a_valid = 1'b1;
            src_b_valid = 1'b1;
            is_int      = 1'b1;
            alu_wr      = 1'b1;
            case ({opcode[3], f7, f3})
               {1'b0, 7'h00, 3'd0}: op = OP_ADDU;
               {1'b0, 7'h20, 3'd0}: op = OP_SUBU;
               {1'b0, 7'h00, 3'd1}: op = OP_SLL;
               {1'b0, 7'h00, 3'd2}: op = OP_SLT;
               {1'b0, 7'h00, 3'd3}: op = OP_SLTU;
               {1'b0, 7'h00, 3'd4}: op = OP_XOR;
               {1'b0, 7'h00, 3'd5}: op = OP_SRL;
               {1'b0, 7'h20, 3'd5}: op = OP_SRA;
               {1'b0, 7'h00, 3'd6}: op = OP_OR;
               {1'b0, 7'h00, 3'd7}: op = OP_AND;
               {1'b0, 7'h01, 3'd0}: op = OP_MUL;
               {1'b0, 7'h01, 3'd1}: op = OP_MULH;
               {1'b0, 7'h01, 3'd3}: op = OP_MULHU;
               {1'b0, 7'h01, 3'd4}: op = OP_DIV;
               {1'b0, 7'h01, 3'd5}: op = OP_DIVU;
               {1'b0, 7'h01, 3'd6}: op = OP_REM;
               {1'b0, 7'h01, 3'd7}: op = OP_REMU;
               {1'b1, 7'h00, 3'd0}: op = mode64 ? OP_ADDW : OP_II;   // word forms need rv64 mode
               {1'b1, 7'h20, 3'd0}: op = mode64 ? OP_SUBW : OP_II;
               {1'b1, 7'h00, 3'd1}: op = mode64 ? OP_SLLW : OP_II;
               {1'b1, 7'h00, 3'd5}: op = mode64 ? OP_SRLW : OP_II;
               {1'b1, 7'h20, 3'd5}: op = mode64 ? OP_SRAW : OP_II;
               {1'b1, 7'h01, 3'd0}: op = mode64 ? OP_MULW : OP_II;
               {1'b1, 7'h01, 3'd4}: op = mode64 ? OP_DIVW : OP_II;
               {1'b1, 7'h01, 3'd5}: op = mode64 ? OP_DIVUW : OP_II;
               {1'b1, 7'h01, 3'd6}: op = mode64 ? OP_REMW : OP_II;
               {1'b1, 7'h01, 3'd7}: op = mode64 ? OP_REMUW : OP_II;
               default: op = OP_II;
            endcase
         end
         OPC_LUI:
         begin
            dst     = rd;
            is_int  = 1'b1;
            alu_wr  = 1'b1;
            imm_fmt = IMM_U;
            op      = OP_LUI;
         end
         OPC_BRANCH:
         begin
            src_a       = rs1;
            src_b       = rs2;
            src_a_valid = 1'b1;
            src_b_valid = 1'b1;
            is_int      = 1'b1;
            is_br       = 1'b1;
            imm_fmt     = IMM_B_PC;
            case (f3)
               3'd0: op = OP_BEQ;
               3'd1: op = OP_BNE;
               3'd4: op = OP_BLT;
               3'd5: op = OP_BGE;
               3'd6: op = OP_BLTU;
               3'd7: op = OP_BGEU;
               default: op = OP_II;
            endcase
         end
         OPC_JALR:
         begin
            dst         = rd;
            src_a       = rs1;
            src_a_valid = 1'b1;
            is_int      = 1'b1;
            is_br       = 1'b1;
            imm_fmt     = IMM_I;
            if (f3 != 3'd0)
               op = OP_II;
            else if (rd != '0)
               op = OP_JALR;
            else
               op = (rs1 == 5'd1 || rs1 == 5'd5) ? OP_RET : OP_JR;   // x1/x5 are link regs
         end
         OPC_JAL:
         begin
            dst     = rd;
            is_int  = 1'b1;
            is_br   = 1'b1;
            imm_fmt = IMM_J_PC;
            op      = (rd == '0) ? OP_J : OP_JAL;
         end
         default: op = OP_II;   // includes system opcode 0x73
      endcase

      dst_valid = (dst != '0);

      if (op == OP_II)
      begin
         dst         = '0;
         src_a       = '0;
         src_b       = '0;
         dst_valid   = 1'b0;
         src_a_valid = 1'b0;
         src_b_valid = 1'b0;
         is_int      = 1'b0;
         is_mem      = 1'b0;
         is_store    = 1'b0;
         is_br       = 1'b0;
         imm_fmt     = IMM_NONE;
      end
      else if (alu_wr && rd == '0)
         op = OP_NOP;
   end

   assign u.op          = op;
   assign u.dst         = dst;
   assign u.dst_valid   = dst_valid;
   assign u.src_a       = src_a;
   assign u.src_a_valid = src_a_valid;
   assign u.src_b       = src_b;
   assign u.src_b_valid = src_b_valid;
   assign u.is_int      = is_int;
   assign u.is_mem      = is_mem;
   assign u.is_store    = is_store;
   assign u.is_br       = is_br;
   assign u.imm_fmt     = imm_fmt;

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen import decode_pkg::*;
(
   input  insn_t insn,
   input  xlen_t pc,
   input  logic  mode64,
   uop_if.gen    u
);

   xlen_t imm_raw;
   xlen_t pc_sum;
   logic  pc_rel;

   always_comb
   begin
      imm_raw = '0;
      pc_rel  = 1'b0;
      case (u.imm_fmt)
         IMM_I: imm_raw = {{(XLEN-12){insn[31]}}, insn[31:20]};
         IMM_S: imm_raw = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
         IMM_U: imm_raw = {{(XLEN-32){insn[31]}}, insn[31:12], 12'd0};
         IMM_B_PC:
         begin
            imm_raw = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
                       insn[11:8], 1'b0};
            pc_rel  = 1'b1;
         end
         IMM_J_PC:
         begin
            imm_raw = {{(XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
                       insn[30:21], 1'b0};
            pc_rel  = 1'b1;
         end
         IMM_U_PC:
         begin
            imm_raw = {{(XLEN-32){insn[31]}}, insn[31:12], 12'd0};
            pc_rel  = 1'b1;
         end
         default: imm_raw = '0;   // IMM_NONE
      endcase
   end

   assign pc_sum = pc + imm_raw;

   // rv32 mode wraps the target at 32 bits
   always_comb
   begin
      if (!pc_rel)
         u.imm = imm_raw;
      else if (mode64)
         u.imm = pc_sum;
      else
         u.imm = {{(XLEN-32){pc_sum[31]}}, pc_sum[31:0]};
   end

endmodule

// ==== rtl/uop_skid_buffer.sv ====
`timescale 1ns/1ps

module uop_skid_buffer import decode_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   output logic     in_ready,
   uop_if.sink      u,
   output logic     out_valid,
   input  logic     out_ready,
   output uop_op_t  out_op,
   output reg_idx_t out_dst,
   output logic     out_dst_valid,
   output reg_idx_t out_src_a,
   output logic     out_src_a_valid,
   output reg_idx_t out_src_b,
   output logic     out_src_b_valid,
   output xlen_t    out_imm,
   output logic     out_is_int,
   output logic     out_is_mem,
   output logic     out_is_store,
   output logic     out_is_br
);

   uop_vec_t   mem [BUF_DEPTH];
   uop_vec_t   wr_data;
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       push;
   logic       pop;

   assign wr_data = {u.op, u.dst, u.dst_valid, u.src_a, u.src_a_valid, u.src_b,
                     u.src_b_valid, u.imm, u.is_int, u.is_mem, u.is_store, u.is_br};

   assign in_ready  = (count < BUF_DEPTH);
   assign out_valid = (count != 2'd0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         if (push && !pop)
            count <= count + 2'd1;
         else if (pop && !push)
            count <= count - 2'd1;   // push with pop keeps count
      end
   end

   assign {out_op, out_dst, out_dst_valid, out_src_a, out_src_a_valid, out_src_b,
           out_src_b_valid, out_imm, out_is_int, out_is_mem, out_is_store,
           out_is_br} = mem[rd_ptr];

endmodule

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit import decode_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     mode64,
   input  logic     in_valid,
   output logic     in_ready,
   input  insn_t    insn,
   input  xlen_t    pc,
   output logic     out_valid,
   input  logic     out_ready,
   output uop_op_t  out_op,
   output reg_idx_t out_dst,
   output logic     out_dst_valid,
   output reg_idx_t out_src_a,
   output logic     out_src_a_valid,
   output reg_idx_t out_src_b,
   output logic     out_src_b_valid,
   output xlen_t    out_imm,
   output logic     out_is_int,
   output logic     out_is_mem,
   output logic     out_is_store,
   output logic     out_is_br
);

   uop_if u ();

   op_decode u_op_decode (
      .insn   (insn),
      .mode64 (mode64),
      .u      (u.dec)
   );

   imm_gen u_imm_gen (
      .insn   (insn),
      .pc     (pc),
      .mode64 (mode64),
      .u      (u.gen)
   );

   // one cycle from accept to out_valid
   uop_skid_buffer u_buf (
      .clk             (clk),
      .arst_n          (arst_n),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .u               (u.sink),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .out_op          (out_op),
      .out_dst         (out_dst),
      .out_dst_valid   (out_dst_valid),
      .out_src_a       (out_src_a),
      .out_src_a_valid (out_src_a_valid),
      .out_src_b       (out_src_b),
      .out_src_b_valid (out_src_b_valid),
      .out_imm         (out_imm),
      .out_is_int      (out_is_int),
      .out_is_mem      (out_is_mem),
      .out_is_store    (out_is_store),
      .out_is_br       (out_is_br)
   );

endmodule

// ==== tests/decode_unit_props.sv ====
`timescale 1ns/1ps

module decode_unit_props import decode_pkg::*;
(
   input logic     clk,
   input logic     arst_n,
   input logic     out_valid,
   input logic     out_ready,
   input uop_op_t  out_op,
   input reg_idx_t out_dst,
   input logic     out_dst_valid,
   input reg_idx_t out_src_a,
   input logic     out_src_a_valid,
   input reg_idx_t out_src_b,
   input logic     out_src_b_valid,
   input xlen_t    out_imm,
   input logic     out_is_int,
   input logic     out_is_mem,
   input logic     out_is_store,
   input logic     out_is_br
);

   int unsigned n_fail = 0;

   property stalled_output_holds;
      @(posedge clk) disable iff (!arst_n)
         out_valid && !out_ready |=> out_valid && $stable(out_op) && $stable(out_dst)
            && $stable(out_dst_valid) && $stable(out_src_a) && $stable(out_src_a_valid)
            && $stable(out_src_b) && $stable(out_src_b_valid) && $stable(out_imm)
            && $stable({out_is_int, out_is_mem, out_is_store, out_is_br});
   endproperty

   property empty_after_reset;
      @(posedge clk) $rose(arst_n) |-> !out_valid;
   endproperty

   stall_hold_a: assert property (stalled_output_holds)
   else
   begin
      n_fail++;
      $error("micro-op changed while held by back-pressure");
   end

   reset_empty_a: assert property (empty_after_reset)
   else
   begin
      n_fail++;
      $error("out_valid high right after reset release");
   end

endmodule

bind uop_skid_buffer decode_unit_props u_props (
   .clk             (clk),
   .arst_n          (arst_n),
   .out_valid       (out_valid),
   .out_ready       (out_ready),
   .out_op          (out_op),
   .out_dst         (out_dst),
   .out_dst_valid   (out_dst_valid),
   .out_src_a       (out_src_a),
   .out_src_a_valid (out_src_a_valid),
   .out_src_b       (out_src_b),
   .out_src_b_valid (out_src_b_valid),
   .out_imm         (out_imm),
   .out_is_int      (out_is_int),
   .out_is_mem      (out_is_mem),
   .out_is_store    (out_is_store),
   .out_is_br       (out_is_br)
);

// ==== tests/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one field per DUT output
typedef struct packed {
   uop_op_t  op;
   reg_idx_t dst;
   logic     dst_valid;
   reg_idx_t src_a;
   logic     src_a_valid;
   reg_idx_t src_b;
   logic     src_b_valid;
   xlen_t    imm;
   logic     is_int;
   logic     is_mem;
   logic     is_store;
   logic     is_br;
} exp_uop_t;

// replicate bit bits-1 of v upward
function automatic xlen_t sign_extend(input xlen_t v, input int bits);
   xlen_t sh;
   sh = v << (XLEN - bits);
   return xlen_t'($signed(sh) >>> (XLEN - bits));
endfunction

function automatic exp_uop_t decode_model_f(input insn_t insn, input xlen_t pc,
                                            input logic mode64);
   exp_uop_t   r;
   logic [6:0] opc;
   logic [2:0] f3;
   logic [6:0] f7;
   reg_idx_t   rd;
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   logic       use_rd;
   logic       use_rs1;
   logic       use_rs2;
   logic       alu;      // dropped to a nop when rd is x0
   logic       pc_rel;
   xlen_t      imm_i;
   xlen_t      imm_u;
   xlen_t      off;

   opc     = insn[6:0];
   f3      = insn[14:12];
   f7      = insn[31:25];
   rd      = insn[11:7];
   rs1     = insn[19:15];
   rs2     = insn[24:20];
   imm_i   = sign_extend(xlen_t'(insn[31:20]), 12);
   imm_u   = sign_extend(xlen_t'({insn[31:12], 12'd0}), 32);
   r       = '0;
   r.op    = OP_II;
   use_rd  = 1'b0;
   use_rs1 = 1'b0;
   use_rs2 = 1'b0;
   alu     = 1'b0;
   pc_rel  = 1'b0;
   off     = '0;

   case (opc)
      OPC_LOAD:
      begin
         {use_rd, use_rs1, r.is_mem} = 3'b111;
         off = imm_i;
         case (f3)
            3'd0: r.op = OP_LB;
            3'd1: r.op = OP_LH;
            3'd2: r.op = OP_LW;
            3'd3: r.op = OP_LD;
            3'd4: r.op = OP_LBU;
            3'd5: r.op = OP_LHU;
            3'd6: r.op = OP_LWU;
            default: r.op = OP_II;
         endcase
      end
      OPC_MISC_MEM: r.op = OP_NOP;
      OPC_OP_IMM:
      begin
         {use_rd, use_rs1, r.is_int, alu} = 4'b1111;
         off = imm_i;
         case (f3)
            3'd0: r.op = OP_ADDI;
            3'd1: r.op = (insn[31:26] == 6'h00) ? OP_SLLI : OP_II;
            3'd2: r.op = OP_SLTI;
            3'd3: r.op = OP_SLTIU;
            3'd4: r.op = OP_XORI;
            3'd5:
            begin
               if (insn[31:26] == 6'h00)
                  r.op = OP_SRLI;
               else if (insn[31:26] == 6'h10)
                  r.op = OP_SRAI;
            end
            3'd6: r.op = OP_ORI;
            3'd7: r.op = OP_ANDI;
         endcase
      end
      OPC_AUIPC:
      begin
         {use_rd, r.is_int, alu, pc_rel} = 4'b1111;
         off  = imm_u;
         r.op = OP_AUIPC;
      end
      OPC_LUI:
      begin
         {use_rd, r.is_int, alu} = 3'b111;
         off  = imm_u;
         r.op = OP_LUI;
      end
      OPC_OP_IMM_32:
      begin
         {use_rd, use_rs1, r.is_int, alu} = 4'b1111;
         off = imm_i;
         if (!mode64)
            r.op = OP_II;
         else if (f3 == 3'd0)
            r.op = OP_ADDIW;   // any f7
         else if (f3 == 3'd1 && f7 == 7'h00)
            r.op = OP_SLLIW;
         else if (f3 == 3'd5 && f7 == 7'h00)
            r.op = OP_SRLIW;
         else if (f3 == 3'd5 && f7 == 7'h20)
            r.op = OP_SRAIW;
      end
      OPC_STORE:
      begin
         {use_rs1, use_rs2, r.is_mem, r.is_store} = 4'b1111;
         off = sign_extend(xlen_t'({insn[31:25], insn[11:7]}), 12);
         case (f3)
            3'd0: r.op = OP_SB;
            3'd1: r.op = OP_SH;
            3'd2: r.op = OP_SW;
            3'd3: r.op = OP_SD;
            default: r.op = OP_II;
         endcase
      end
      OPC_OP:
      begin
         {use_rd, use_rs1, use_rs2, r.is_int, alu} = 5'b11111;
         if (f7 == 7'h00)
         begin
            case (f3)
               3'd0: r.op = OP_ADDU;
               3'd1: r.op = OP_SLL;
               3'd2: r.op = OP_SLT;
               3'd3: r.op = OP_SLTU;
               3'd4: r.op = OP_XOR;
               3'd5: r.op = OP_SRL;
               3'd6: r.op = OP_OR;
               3'd7: r.op = OP_AND;
            endcase
         end
         else if (f7 == 7'h20 && f3 == 3'd0)
            r.op = OP_SUBU;
         else if (f7 == 7'h20 && f3 == 3'd5)
            r.op = OP_SRA;
         else if (f7 == 7'h01)
         begin
            case (f3)
               3'd0: r.op = OP_MUL;
               3'd1: r.op = OP_MULH;
               3'd3: r.op = OP_MULHU;
               3'd4: r.op = OP_DIV;
               3'd5: r.op = OP_DIVU;
               3'd6: r.op = OP_REM;
               3'd7: r.op = OP_REMU;
               default: r.op = OP_II;   // mulhsu is not supported
            endcase
         end
      end
      OPC_OP_32:
      begin
         {use_rd, use_rs1, use_rs2, r.is_int, alu} = 5'b11111;
         if (mode64)
         begin
            case ({f7, f3})
               {7'h00, 3'd0}: r.op = OP_ADDW;
               {7'h00, 3'd1}: r.op = OP_SLLW;
               {7'h00, 3'd5}: r.op = OP_SRLW;
               {7'h20, 3'd0}: r.op = OP_SUBW;
               {7'h20, 3'd5}: r.op = OP_SRAW;
               {7'h01, 3'd0}: r.op = OP_MULW;
               {7'h01, 3'd4}: r.op = OP_DIVW;
               {7'h01, 3'd5}: r.op = OP_DIVUW;
               {7'h01, 3'd6}: r.op = OP_REMW;
               {7'h01, 3'd7}: r.op = OP_REMUW;
               default: r.op = OP_II;
            endcase
         end
      end
      OPC_BRANCH:
      begin
         {use_rs1, use_rs2, r.is_int, r.is_br, pc_rel} = 5'b11111;
         off = sign_extend(xlen_t'({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}), 13);
         case (f3)
            3'd0: r.op = OP_BEQ;
            3'd1: r.op = OP_BNE;
            3'd4: r.op = OP_BLT;
            3'd5: r.op = OP_BGE;
            3'd6: r.op = OP_BLTU;
            3'd7: r.op = OP_BGEU;
            default: r.op = OP_II;
         endcase
      end
      OPC_JALR:
      begin
         {use_rd, use_rs1, r.is_int, r.is_br} = 4'b1111;
         off = imm_i;
         if (f3 != 3'd0)
            r.op = OP_II;
         else if (rd != 5'd0)
            r.op = OP_JALR;
         else if (rs1 == 5'd1 || rs1 == 5'd5)
            r.op = OP_RET;
         else
            r.op = OP_JR;
      end
      OPC_JAL:
      begin
         {use_rd, r.is_int, r.is_br, pc_rel} = 4'b1111;
         off  = sign_extend(xlen_t'({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}), 21);
         r.op = (rd == 5'd0) ? OP_J : OP_JAL;
      end
      default: r.op = OP_II;
   endcase

   // illegal encodings carry nothing
   if (r.op == OP_II)
   begin
      r    = '0;
      r.op = OP_II;
      return r;
   end

   r.dst         = use_rd ? rd : 5'd0;
   r.dst_valid   = use_rd && (rd != 5'd0);
   r.src_a       = use_rs1 ? rs1 : 5'd0;
   r.src_a_valid = use_rs1;
   r.src_b       = use_rs2 ? rs2 : 5'd0;
   r.src_b_valid = use_rs2;
   if (alu && rd == 5'd0)
      r.op = OP_NOP;

   if (!pc_rel)
      r.imm = off;
   else if (mode64)
      r.imm = pc + off;
   else
      r.imm = sign_extend(pc + off, 32);   // rv32 target wraps
   return r;
endfunction

`endif

// ==== tests/tb_decode_unit.sv ====
`timescale 1ns/1ps

module tb_decode_unit import decode_pkg::*; ();

   localparam int N_TXN      = 2000;
   localparam int SEED       = 2;
   localparam int CLK_NS     = 4;
   localparam int RST_CYCLES = 8;

   // 0x73 is the dropped system opcode
   localparam logic [6:0] OPC_LIST [13] = '{
      OPC_LOAD, OPC_MISC_MEM, OPC_OP_IMM, OPC_AUIPC, OPC_OP_IMM_32, OPC_STORE,
      OPC_OP, OPC_LUI, OPC_OP_32, OPC_BRANCH, OPC_JALR, OPC_JAL, 7'h73
   };

   logic     clk = 1'b0;
   logic     arst_n;
   logic     mode64;
   logic     in_valid;
   logic     in_ready;
   insn_t    insn;
   xlen_t    pc;
   logic     out_valid;
   logic     out_ready;
   uop_op_t  out_op;
   reg_idx_t out_dst;
   logic     out_dst_valid;
   reg_idx_t out_src_a;
   logic     out_src_a_valid;
   reg_idx_t out_src_b;
   logic     out_src_b_valid;
   xlen_t    out_imm;
   logic     out_is_int;
   logic     out_is_mem;
   logic     out_is_store;
   logic     out_is_br;

   `include "decode_model.svh"

   exp_uop_t exp_q [$];
   insn_t    insn_q [$];
   logic     in_taken = 1'b0;   // accept seen at the last edge
   int       n_acc    = 0;
   int       n_out    = 0;
   int       n_val    = 0;
   int       n_proto  = 0;
   int       n_assert;

   decode_unit DUT (
      .clk             (clk),
      .arst_n          (arst_n),
      .mode64          (mode64),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .insn            (insn),
      .pc              (pc),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .out_op          (out_op),
      .out_dst         (out_dst),
      .out_dst_valid   (out_dst_valid),
      .out_src_a       (out_src_a),
      .out_src_a_valid (out_src_a_valid),
      .out_src_b       (out_src_b),
      .out_src_b_valid (out_src_b_valid),
      .out_imm         (out_imm),
      .out_is_int      (out_is_int),
      .out_is_mem      (out_is_mem),
      .out_is_store    (out_is_store),
      .out_is_br       (out_is_br)
   );

   always #(CLK_NS / 2) clk = ~clk;

   task automatic check_op(input string name, input uop_op_t exp, input uop_op_t act);
      if (exp !== act)
      begin
         n_val++;
         $display("FAIL %s: expected %0d, got %0d", name, exp, act);
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
      if (exp !== act)
      begin
         n_val++;
         $display("FAIL %s: expected x%0d, got x%0d", name, exp, act);
      end
   endtask

   task automatic check_imm(input string name, input xlen_t exp, input xlen_t act);
      if (exp !== act)
      begin
         n_val++;
         $display("FAIL %s: expected %016h, got %016h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         n_val++;
         $display("FAIL %s: expected %b, got %b", name, exp, act);
      end
   endtask

   task automatic compare_uop(input exp_uop_t e, input insn_t src);
      string tag;
      tag = $sformatf("uop %0d insn %08h", n_out, src);
      check_op({tag, " op"}, e.op, out_op);
      check_reg({tag, " dst"}, e.dst, out_dst);
      check_bit({tag, " dst_valid"}, e.dst_valid, out_dst_valid);
      check_reg({tag, " src_a"}, e.src_a, out_src_a);
      check_bit({tag, " src_a_valid"}, e.src_a_valid, out_src_a_valid);
      check_reg({tag, " src_b"}, e.src_b, out_src_b);
      check_bit({tag, " src_b_valid"}, e.src_b_valid, out_src_b_valid);
      check_imm({tag, " imm"}, e.imm, out_imm);
      check_bit({tag, " is_int"}, e.is_int, out_is_int);
      check_bit({tag, " is_mem"}, e.is_mem, out_is_mem);
      check_bit({tag, " is_store"}, e.is_store, out_is_store);
      check_bit({tag, " is_br"}, e.is_br, out_is_br);
   endtask

   // biased toward x0 and the link registers
   function automatic insn_t random_insn();
      logic [6:0] opc;
      logic [6:0] f7;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      int         pick;
      pick = $urandom % 16;
      opc  = (pick < 13) ? OPC_LIST[pick] : 7'($urandom);
      case ($urandom % 4)
         0: f7 = 7'h00;
         1: f7 = 7'h20;
         2: f7 = 7'h01;
         default: f7 = 7'($urandom);
      endcase
      rd = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
      if ($urandom % 4 == 0)
         rs1 = ($urandom % 2 == 0) ? 5'd1 : 5'd5;
      else
         rs1 = 5'($urandom);
      return {f7, 5'($urandom), rs1, 3'($urandom), rd, opc};
   endfunction

   // sample mid-cycle, both sides are settled
   always @(negedge clk)
   begin
      if (arst_n)
      begin
         in_taken = in_valid && in_ready;
         if (out_valid && out_ready)
         begin
            if (exp_q.size() == 0)
            begin
               n_proto++;
               $display("output transfer %0d came with no instruction outstanding", n_out);
            end
            else
               compare_uop(exp_q.pop_front(), insn_q.pop_front());
            n_out++;
         end
         if (in_taken)
         begin
            exp_q.push_back(decode_model_f(insn, pc, mode64));
            insn_q.push_back(insn);
            n_acc++;
         end
      end
   end

   initial
   begin
      #(CLK_NS * (N_TXN * 20 + RST_CYCLES));
      $display("timeout after %0d of %0d micro-ops", n_out, N_TXN);
      $display("tests failed");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      arst_n    = 1'b0;
      mode64    = 1'b0;
      in_valid  = 1'b0;
      insn      = '0;
      pc        = '0;
      out_ready = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;

      while (n_acc < N_TXN)
      begin
         @(posedge clk);
         #1;
         out_ready = ($urandom % 10) >= 3;
         if (!in_valid || in_taken)   // hold a pending transfer
         begin
            in_valid = (n_acc < N_TXN) && ($urandom % 4 != 0);
            if (in_valid)
            begin
               insn   = random_insn();
               pc     = {$urandom, $urandom};
               mode64 = 1'($urandom);
            end
         end
      end

      in_valid  = 1'b0;
      out_ready = 1'b1;
      wait (n_out >= N_TXN);
      repeat (2) @(posedge clk);

      n_assert = int'(DUT.u_buf.u_props.n_fail);
      $display("%0d of %0d checked: %0d value errors, %0d protocol errors, %0d assertion errors",
               n_out, N_TXN, n_val, n_proto, n_assert);
      if (n_val == 0 && n_proto == 0 && n_assert == 0 && exp_q.size() == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== decode_unit.f ====
+incdir+tests
rtl/decode_pkg.sv
rtl/uop_if.sv
rtl/op_decode.sv
rtl/imm_gen.sv
rtl/uop_skid_buffer.sv
rtl/decode_unit.sv
tests/decode_unit_props.sv
tests/tb_decode_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the decode unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f decode_unit.f --top-module tb_decode_unit

./obj_dir/Vtb_decode_unit +verilator+error+limit+1000 | tee sim.log

if grep -qx "all tests passed" sim.log; then
   exit 0
else
   exit 1
fi
